//--- include/controlUnit_params.svh
`ifndef CONTROL_UNIT_PARAMS_SVH
`define CONTROL_UNIT_PARAMS_SVH

// Instruction register fields.
`define OPCODE_WIDTH 6
`define OFFSET_WIDTH 16
`define FUNCT_WIDTH 6

// Sequencer registers.
`define STATE_WIDTH 3
`define STEP_WIDTH 3

// Decoder result.
`define CLASS_WIDTH 3

// Datapath control fields.
`define ALU_OP_WIDTH 3
`define MEM_TO_REG_WIDTH 4

// Length of fetch plus decode, in cycles.
`define FETCH_STEPS 6

`endif

//--- rtl/isaPkg.sv
`default_nettype none

`include "controlUnit_params.svh"

package isaPkg;

    // Opcode field, bits 31:26 of the instruction.
    localparam logic [`OPCODE_WIDTH-1:0] OP_RTYPE = 6'b000000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_JUMP  = 6'b000010;
    localparam logic [`OPCODE_WIDTH-1:0] OP_ADDI  = 6'b001000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_RESET = 6'b111111;

    // Funct field of R-type words.
    localparam logic [`FUNCT_WIDTH-1:0] FUNCT_ADD = 6'b100000;
    localparam logic [`FUNCT_WIDTH-1:0] FUNCT_SUB = 6'b100010;
    localparam logic [`FUNCT_WIDTH-1:0] FUNCT_AND = 6'b100100;
    localparam logic [`FUNCT_WIDTH-1:0] FUNCT_SLT = 6'b101010;

endpackage

`default_nettype wire

//--- rtl/controlPkg.sv
`default_nettype none

`include "controlUnit_params.svh"

package controlPkg;

    // Sequencer states.
    localparam logic [`STATE_WIDTH-1:0] ST_COMMON = 3'd0;
    localparam logic [`STATE_WIDTH-1:0] ST_ADD    = 3'd1;
    localparam logic [`STATE_WIDTH-1:0] ST_ADDI   = 3'd2;
    localparam logic [`STATE_WIDTH-1:0] ST_SUB    = 3'd3;
    localparam logic [`STATE_WIDTH-1:0] ST_AND    = 3'd4;
    localparam logic [`STATE_WIDTH-1:0] ST_SLT    = 3'd5;
    localparam logic [`STATE_WIDTH-1:0] ST_JUMP   = 3'd6;
    localparam logic [`STATE_WIDTH-1:0] ST_HALT   = 3'd7;

    // Step numbers inside the common and execute sequences.
    localparam logic [`STEP_WIDTH-1:0] STEP_FIRST       = 3'd0;
    localparam logic [`STEP_WIDTH-1:0] STEP_EXEC_SECOND = 3'd1;
    localparam logic [`STEP_WIDTH-1:0] STEP_PC_WRITE    = 3'd3;
    localparam logic [`STEP_WIDTH-1:0] STEP_REG_READ    = 3'd4;
    localparam logic [`STEP_WIDTH-1:0] STEP_DECODE      = `STEP_WIDTH'(`FETCH_STEPS - 1);

    // Decoded instruction classes.
    localparam logic [`CLASS_WIDTH-1:0] CLASS_NONE  = 3'd0;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_ADD   = 3'd1;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_SUB   = 3'd2;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_AND   = 3'd3;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_SLT   = 3'd4;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_ADDI  = 3'd5;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_JUMP  = 3'd6;
    localparam logic [`CLASS_WIDTH-1:0] CLASS_RESET = 3'd7;

    localparam logic [`ALU_OP_WIDTH-1:0] ALU_NOP = 3'b000;
    localparam logic [`ALU_OP_WIDTH-1:0] ALU_ADD = 3'b001;
    localparam logic [`ALU_OP_WIDTH-1:0] ALU_SUB = 3'b010;
    localparam logic [`ALU_OP_WIDTH-1:0] ALU_AND = 3'b011;
    localparam logic [`ALU_OP_WIDTH-1:0] ALU_SLT = 3'b111;

    // Datapath mux selectors.
    localparam logic [1:0] SRCB_REG    = 2'b00;
    localparam logic [1:0] SRCB_FOUR   = 2'b01;
    localparam logic [1:0] SRCB_IMM    = 2'b10;
    localparam logic [1:0] REGDEST_RT  = 2'b00;
    localparam logic [1:0] REGDEST_RD  = 2'b01;
    localparam logic [`MEM_TO_REG_WIDTH-1:0] MEMTOREG_ALU  = 4'b0000;
    localparam logic [`MEM_TO_REG_WIDTH-1:0] MEMTOREG_LESS = 4'b0100;

endpackage

`default_nettype wire

//--- rtl/instructionDecoder.sv
`default_nettype none

`include "controlUnit_params.svh"

module instructionDecoder
    import isaPkg::*;
    import controlPkg::*;
(
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    input  logic [`FUNCT_WIDTH-1:0]  funct,
    output logic [`CLASS_WIDTH-1:0]  instrClass
);

    always_comb begin
        // Unlisted words fall back to a plain refetch.
        instrClass = CLASS_NONE;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FUNCT_ADD: begin
                        instrClass = CLASS_ADD;
                    end
                    FUNCT_SUB: begin
                        instrClass = CLASS_SUB;
                    end
                    FUNCT_AND: begin
                        instrClass = CLASS_AND;
                    end
                    FUNCT_SLT: begin
                        instrClass = CLASS_SLT;
                    end
                    default: begin
                        instrClass = CLASS_NONE;
                    end
                endcase
            end
            OP_ADDI: begin
                instrClass = CLASS_ADDI;
            end
            OP_JUMP: begin
                instrClass = CLASS_JUMP;
            end
            OP_RESET: begin
                instrClass = CLASS_RESET;
            end
            default: begin
                instrClass = CLASS_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/stepSequencer.sv
`default_nettype none

`include "controlUnit_params.svh"

module stepSequencer
    import controlPkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`CLASS_WIDTH-1:0]  instrClass,
    output logic [`STATE_WIDTH-1:0]  state,
    output logic [`STEP_WIDTH-1:0]   step
);

    logic [`STATE_WIDTH-1:0] nextState;
    logic [`STEP_WIDTH-1:0]  nextStep;

    // Execute state entered from the decode step.
    function automatic logic [`STATE_WIDTH-1:0] classToState(
        input logic [`CLASS_WIDTH-1:0] cls
    );
        logic [`STATE_WIDTH-1:0] target;
        case (cls)
            CLASS_ADD:   target = ST_ADD;
            CLASS_SUB:   target = ST_SUB;
            CLASS_AND:   target = ST_AND;
            CLASS_SLT:   target = ST_SLT;
            CLASS_ADDI:  target = ST_ADDI;
            CLASS_JUMP:  target = ST_JUMP;
            CLASS_RESET: target = ST_HALT;
            default:     target = ST_COMMON;
        endcase
        return target;
    endfunction

    always_comb begin
        nextState = state;
        nextStep  = step + 1'b1;
        case (state)
            ST_COMMON: begin
                if (step == STEP_DECODE) begin
                    nextState = classToState(instrClass);
                    nextStep  = STEP_FIRST;
                end
            end
            ST_ADD, ST_SUB, ST_AND, ST_ADDI: begin
                // Two-cycle execute.
                if (step == STEP_EXEC_SECOND) begin
                    nextState = ST_COMMON;
                    nextStep  = STEP_FIRST;
                end
            end
            ST_SLT, ST_JUMP: begin
                nextState = ST_COMMON;
                nextStep  = STEP_FIRST;
            end
            default: begin
                // Halted until external reset.
                nextState = ST_HALT;
                nextStep  = STEP_FIRST;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_COMMON;
            step  <= STEP_FIRST;
        end else begin
            state <= nextState;
            step  <= nextStep;
        end
    end

endmodule

`default_nettype wire

//--- rtl/controlWordGenerator.sv
`default_nettype none

`include "controlUnit_params.svh"

module controlWordGenerator
    import controlPkg::*;
(
    input  logic [`STATE_WIDTH-1:0]      state,
    input  logic [`STEP_WIDTH-1:0]       step,
    output logic                         pcWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         aWrite,
    output logic                         bWrite,
    output logic                         aluOutWrite,
    output logic                         srcASelect,
    output logic                         pcSourceSelect,
    output logic                         resetOut,
    output logic [`ALU_OP_WIDTH-1:0]     aluOp,
    output logic [1:0]                   srcBSelect,
    output logic [1:0]                   regDestSelect,
    output logic [`MEM_TO_REG_WIDTH-1:0] memToRegSelect
);

    always_comb begin
        pcWrite        = 1'b0;
        irWrite        = 1'b0;
        regWrite       = 1'b0;
        aWrite         = 1'b0;
        bWrite         = 1'b0;
        aluOutWrite    = 1'b0;
        srcASelect     = 1'b0;
        pcSourceSelect = 1'b0;
        resetOut       = 1'b0;
        aluOp          = ALU_NOP;
        srcBSelect     = SRCB_REG;
        regDestSelect  = REGDEST_RT;
        memToRegSelect = MEMTOREG_ALU;

        case (state)
            ST_COMMON: begin
                case (step)
                    STEP_PC_WRITE: begin
                        // Latch the fetched word and PC + 4.
                        aluOp      = ALU_ADD;
                        srcBSelect = SRCB_FOUR;
                        pcWrite    = 1'b1;
                        irWrite    = 1'b1;
                    end
                    STEP_REG_READ: begin
                        aWrite = 1'b1;
                        bWrite = 1'b1;
                    end
                    STEP_DECODE: begin
                        // Decode cycle is idle.
                    end
                    default: begin
                        // PC + 4 while memory settles.
                        aluOp      = ALU_ADD;
                        srcBSelect = SRCB_FOUR;
                    end
                endcase
            end
            ST_ADD, ST_SUB, ST_AND: begin
                aluOutWrite = 1'b1;
                srcASelect  = 1'b1;
                case (state)
                    ST_SUB:  aluOp = ALU_SUB;
                    ST_AND:  aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
                // Write back on the second cycle.
                if (step == STEP_EXEC_SECOND) begin
                    regWrite      = 1'b1;
                    regDestSelect = REGDEST_RD;
                end
            end
            ST_ADDI: begin
                srcASelect = 1'b1;
                if (step == STEP_EXEC_SECOND) begin
                    regWrite = 1'b1;
                    aluOp    = ALU_ADD;
                end else begin
                    aluOp       = ALU_SUB;
                    srcBSelect  = SRCB_IMM;
                    aluOutWrite = 1'b1;
                end
            end
            ST_SLT: begin
                regWrite       = 1'b1;
                srcASelect     = 1'b1;
                aluOp          = ALU_SLT;
                regDestSelect  = REGDEST_RD;
                memToRegSelect = MEMTOREG_LESS;
            end
            ST_JUMP: begin
                pcWrite        = 1'b1;
                pcSourceSelect = 1'b1;
            end
            default: begin
                resetOut = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`default_nettype none

`include "controlUnit_params.svh"

module controlUnit (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [`OPCODE_WIDTH-1:0]     opcode,
    input  logic [`OFFSET_WIDTH-1:0]     offset,
    output logic                         pcWrite,
    output logic                         irWrite,
    output logic                         regWrite,
    output logic                         aWrite,
    output logic                         bWrite,
    output logic                         aluOutWrite,
    output logic                         srcASelect,
    output logic                         pcSourceSelect,
    output logic                         resetOut,
    output logic [`ALU_OP_WIDTH-1:0]     aluOp,
    output logic [1:0]                   srcBSelect,
    output logic [1:0]                   regDestSelect,
    output logic [`MEM_TO_REG_WIDTH-1:0] memToRegSelect
);

    logic [`CLASS_WIDTH-1:0] instrClass;
    logic [`STATE_WIDTH-1:0] state;
    logic [`STEP_WIDTH-1:0]  step;

    // Funct sits in the low bits of the offset.
    instructionDecoder decoder (
        .opcode     (opcode),
        .funct      (offset[`FUNCT_WIDTH-1:0]),
        .instrClass (instrClass)
    );

    stepSequencer sequencer (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state),
        .step       (step)
    );

    controlWordGenerator generator (
        .state          (state),
        .step           (step),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .aWrite         (aWrite),
        .bWrite         (bWrite),
        .aluOutWrite    (aluOutWrite),
        .srcASelect     (srcASelect),
        .pcSourceSelect (pcSourceSelect),
        .resetOut       (resetOut),
        .aluOp          (aluOp),
        .srcBSelect     (srcBSelect),
        .regDestSelect  (regDestSelect),
        .memToRegSelect (memToRegSelect)
    );

endmodule

`default_nettype wire

//--- test/clockGen.sv
`default_nettype none

module clockGen (
    input  logic resetRequest,
    output logic clock,
    output logic reset
);

    localparam int halfPeriod = 20;
    localparam int resetCycles = 2;

    int remaining;

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        remaining = resetCycles;
    end

    always #(halfPeriod) clock = ~clock;

    // Reset covers exactly two rising edges.
    always @(posedge clock) begin
        if (resetRequest) begin
            reset <= 1'b1;
            remaining <= resetCycles;
        end else if (reset) begin
            remaining <= remaining - 1;
            if (remaining == 1) begin
                reset <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/controlUnitChecker.sv
`default_nettype none

`include "controlUnit_params.svh"

module controlUnitChecker
    import isaPkg::*;
    import controlPkg::*;
#(
    parameter int numInstructions = 60
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [`OPCODE_WIDTH-1:0]     opcode,
    input  logic [`OFFSET_WIDTH-1:0]     offset,
    input  logic                         pcWrite,
    input  logic                         irWrite,
    input  logic                         regWrite,
    input  logic                         aWrite,
    input  logic                         bWrite,
    input  logic                         aluOutWrite,
    input  logic                         srcASelect,
    input  logic                         pcSourceSelect,
    input  logic                         resetOut,
    input  logic [`ALU_OP_WIDTH-1:0]     aluOp,
    input  logic [1:0]                   srcBSelect,
    input  logic [1:0]                   regDestSelect,
    input  logic [`MEM_TO_REG_WIDTH-1:0] memToRegSelect,
    output int                           errorCount,
    output int                           testCount,
    output int                           failedTests,
    output logic                         timedOut
);

    localparam int resetCycles = 2;
    localparam int cycleLimit = (8 * numInstructions + resetCycles) * 2;

    logic modelKnown;
    logic [`STATE_WIDTH-1:0] modelState;
    logic [`STEP_WIDTH-1:0] modelStep;
    logic [`STATE_WIDTH-1:0] lastState;
    int testErrors;
    string testName;
    int cycleCount;
    int sinceFetch;
    logic intervalValid;

    logic expPcWrite;
    logic expIrWrite;
    logic expRegWrite;
    logic expAWrite;
    logic expBWrite;
    logic expAluOutWrite;
    logic expSrcA;
    logic expPcSource;
    logic expResetOut;
    logic [`ALU_OP_WIDTH-1:0] expAluOp;
    logic [1:0] expSrcB;
    logic [1:0] expRegDest;
    logic [`MEM_TO_REG_WIDTH-1:0] expMemToReg;

    function automatic logic [`STATE_WIDTH-1:0] executeStateOf(
        input logic [`OPCODE_WIDTH-1:0] op,
        input logic [`FUNCT_WIDTH-1:0] fn
    );
        logic [`STATE_WIDTH-1:0] target;
        target = ST_COMMON;
        if (op == OP_ADDI) begin
            target = ST_ADDI;
        end else if (op == OP_JUMP) begin
            target = ST_JUMP;
        end else if (op == OP_RESET) begin
            target = ST_HALT;
        end else if (op == OP_RTYPE) begin
            if (fn == FUNCT_ADD) target = ST_ADD;
            else if (fn == FUNCT_SUB) target = ST_SUB;
            else if (fn == FUNCT_AND) target = ST_AND;
            else if (fn == FUNCT_SLT) target = ST_SLT;
        end
        return target;
    endfunction

    function automatic string nameOf(input logic [`STATE_WIDTH-1:0] st);
        case (st)
            ST_ADD:  return "add";
            ST_SUB:  return "sub";
            ST_AND:  return "and";
            ST_ADDI: return "addi";
            ST_SLT:  return "slt";
            ST_JUMP: return "j";
            ST_HALT: return "reset opcode";
            default: return "illegal";
        endcase
    endfunction

    // Cycles from one fetch to the next.
    function automatic int lengthOf(input logic [`STATE_WIDTH-1:0] st);
        case (st)
            ST_COMMON:       return `FETCH_STEPS;
            ST_SLT, ST_JUMP: return `FETCH_STEPS + 1;
            default:         return `FETCH_STEPS + 2;
        endcase
    endfunction

    task automatic expectRow(
        input logic [`STATE_WIDTH-1:0] st,
        input logic [`STEP_WIDTH-1:0] sp
    );
        {expPcWrite, expIrWrite, expRegWrite, expAWrite, expBWrite} = '0;
        {expAluOutWrite, expSrcA, expPcSource, expResetOut} = '0;
        expAluOp = ALU_NOP;
        expSrcB = SRCB_REG;
        expRegDest = REGDEST_RT;
        expMemToReg = MEMTOREG_ALU;
        if (st == ST_COMMON) begin
            if (sp <= STEP_PC_WRITE) begin
                expAluOp = ALU_ADD;
                expSrcB = SRCB_FOUR;
            end
            if (sp == STEP_PC_WRITE) begin
                expPcWrite = 1'b1;
                expIrWrite = 1'b1;
            end
            if (sp == STEP_REG_READ) begin
                expAWrite = 1'b1;
                expBWrite = 1'b1;
            end
        end else if (st == ST_ADD || st == ST_SUB || st == ST_AND) begin
            expAluOutWrite = 1'b1;
            expSrcA = 1'b1;
            expAluOp = (st == ST_ADD) ? ALU_ADD : (st == ST_SUB) ? ALU_SUB : ALU_AND;
            if (sp == STEP_EXEC_SECOND) begin
                expRegWrite = 1'b1;
                expRegDest = REGDEST_RD;
            end
        end else if (st == ST_ADDI) begin
            expSrcA = 1'b1;
            if (sp == STEP_FIRST) begin
                expAluOp = ALU_SUB;
                expSrcB = SRCB_IMM;
                expAluOutWrite = 1'b1;
            end else begin
                expRegWrite = 1'b1;
                expAluOp = ALU_ADD;
            end
        end else if (st == ST_SLT) begin
            expRegWrite = 1'b1;
            expSrcA = 1'b1;
            expAluOp = ALU_SLT;
            expRegDest = REGDEST_RD;
            expMemToReg = MEMTOREG_LESS;
        end else if (st == ST_JUMP) begin
            expPcWrite = 1'b1;
            expPcSource = 1'b1;
        end else begin
            expResetOut = 1'b1;
        end
    endtask

    task automatic recordError();
        errorCount = errorCount + 1;
        testErrors = testErrors + 1;
    endtask

    task automatic compareField(
        input string name,
        input logic [3:0] expected,
        input logic [3:0] actual
    );
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %0h, got %0h in test %0d (%s)",
                     $time, name, expected, actual, testCount + 1, testName);
            recordError();
        end
    endtask

    task automatic compareOutputs();
        compareField("pcWrite", 4'(expPcWrite), 4'(pcWrite));
        compareField("irWrite", 4'(expIrWrite), 4'(irWrite));
        compareField("regWrite", 4'(expRegWrite), 4'(regWrite));
        compareField("aWrite", 4'(expAWrite), 4'(aWrite));
        compareField("bWrite", 4'(expBWrite), 4'(bWrite));
        compareField("aluOutWrite", 4'(expAluOutWrite), 4'(aluOutWrite));
        compareField("srcASelect", 4'(expSrcA), 4'(srcASelect));
        compareField("pcSourceSelect", 4'(expPcSource), 4'(pcSourceSelect));
        compareField("resetOut", 4'(expResetOut), 4'(resetOut));
        compareField("aluOp", 4'(expAluOp), 4'(aluOp));
        compareField("srcBSelect", 4'(expSrcB), 4'(srcBSelect));
        compareField("regDestSelect", 4'(expRegDest), 4'(regDestSelect));
        compareField("memToRegSelect", expMemToReg, memToRegSelect);
    endtask

    task automatic checkFetchInterval();
        if (reset) begin
            intervalValid = 1'b0;
        end else begin
            sinceFetch = sinceFetch + 1;
            if (irWrite === 1'b1) begin
                if (intervalValid && sinceFetch != lengthOf(lastState)) begin
                    $display("Fetch came %0d cycles after the previous one, expected %0d for %s",
                             sinceFetch, lengthOf(lastState), nameOf(lastState));
                    recordError();
                end
                sinceFetch = 0;
                intervalValid = 1'b1;
            end
        end
    endtask

    task automatic advanceModel();
        if (reset) begin
            modelState = ST_COMMON;
            modelStep = STEP_FIRST;
        end else if (modelState == ST_COMMON) begin
            if (modelStep == STEP_DECODE) begin
                modelState = executeStateOf(opcode, offset[`FUNCT_WIDTH-1:0]);
                modelStep = STEP_FIRST;
                lastState = modelState;
                testName = nameOf(modelState);
            end else begin
                modelStep = modelStep + 1'b1;
            end
        end else if (modelState == ST_SLT || modelState == ST_JUMP) begin
            modelState = ST_COMMON;
            modelStep = STEP_FIRST;
        end else if (modelState != ST_HALT) begin
            if (modelStep == STEP_EXEC_SECOND) begin
                modelState = ST_COMMON;
                modelStep = STEP_FIRST;
            end else begin
                modelStep = modelStep + 1'b1;
            end
        end
    endtask

    task automatic finishTest();
        testCount = testCount + 1;
        if (testErrors == 0) begin
            $display("Test %0d (%s) passed", testCount, testName);
        end else begin
            failedTests = failedTests + 1;
            $display("Test %0d (%s) failed with %0d errors", testCount, testName, testErrors);
        end
        testErrors = 0;
        testName = "fetch";
    endtask

    initial begin
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        timedOut = 1'b0;
        modelKnown = 1'b0;
        lastState = ST_COMMON;
        testErrors = 0;
        testName = "fetch";
        cycleCount = 0;
        sinceFetch = 0;
        intervalValid = 1'b0;
    end

    always @(negedge clock) begin
        logic [`STATE_WIDTH-1:0] prevState;
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit && !timedOut) begin
            $display("Run timed out after %0d cycles", cycleCount);
            timedOut = 1'b1;
        end
        if (modelKnown) begin
            expectRow(modelState, modelStep);
            compareOutputs();
        end
        checkFetchInterval();
        prevState = modelState;
        if (modelKnown || reset) begin
            advanceModel();
            if (reset) begin
                // The halt test ends at the external reset.
                if (modelKnown && prevState == ST_HALT) begin
                    finishTest();
                end
                modelKnown = 1'b1;
            end else if (modelState == ST_COMMON && modelStep == STEP_FIRST) begin
                finishTest();
            end
        end
    end

endmodule

`default_nettype wire

//--- test/controlUnitTb.sv
`default_nettype none

`include "controlUnit_params.svh"

module controlUnitTb
    import isaPkg::*;
();

    localparam int numInstructions = 60;
    localparam int haltWait = 3;

    logic clock;
    logic reset;
    logic resetRequest;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`OFFSET_WIDTH-1:0] offset;
    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic aWrite;
    logic bWrite;
    logic aluOutWrite;
    logic srcASelect;
    logic pcSourceSelect;
    logic resetOut;
    logic [`ALU_OP_WIDTH-1:0] aluOp;
    logic [1:0] srcBSelect;
    logic [1:0] regDestSelect;
    logic [`MEM_TO_REG_WIDTH-1:0] memToRegSelect;

    integer seed;
    int issued;
    int haltCycles;
    logic fetchSeen;
    logic runDone;
    int errorCount;
    int testCount;
    int failedTests;
    logic timedOut;

    clockGen clocks (
        .resetRequest (resetRequest),
        .clock        (clock),
        .reset        (reset)
    );

    controlUnit u_dut (
        .clock          (clock),
        .reset          (reset),
        .opcode         (opcode),
        .offset         (offset),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .aWrite         (aWrite),
        .bWrite         (bWrite),
        .aluOutWrite    (aluOutWrite),
        .srcASelect     (srcASelect),
        .pcSourceSelect (pcSourceSelect),
        .resetOut       (resetOut),
        .aluOp          (aluOp),
        .srcBSelect     (srcBSelect),
        .regDestSelect  (regDestSelect),
        .memToRegSelect (memToRegSelect)
    );

    controlUnitChecker #(
        .numInstructions (numInstructions)
    ) scoreboard (
        .clock          (clock),
        .reset          (reset),
        .opcode         (opcode),
        .offset         (offset),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .aWrite         (aWrite),
        .bWrite         (bWrite),
        .aluOutWrite    (aluOutWrite),
        .srcASelect     (srcASelect),
        .pcSourceSelect (pcSourceSelect),
        .resetOut       (resetOut),
        .aluOp          (aluOp),
        .srcBSelect     (srcBSelect),
        .regDestSelect  (regDestSelect),
        .memToRegSelect (memToRegSelect),
        .errorCount     (errorCount),
        .testCount      (testCount),
        .failedTests    (failedTests),
        .timedOut       (timedOut)
    );

    // Mostly legal words, some illegal ones, the reset opcode rarely.
    task automatic drawInstruction();
        int pick;
        logic [`OPCODE_WIDTH-1:0] op;
        logic [`OFFSET_WIDTH-1:0] off;
        logic [`FUNCT_WIDTH-1:0] fn;
        pick = $unsigned($random(seed)) % 32;
        off = 16'($random(seed));
        op = OP_RTYPE;
        if (pick < 20) begin
            case (pick % 4)
                0: fn = FUNCT_ADD;
                1: fn = FUNCT_SUB;
                2: fn = FUNCT_AND;
                default: fn = FUNCT_SLT;
            endcase
            off[`FUNCT_WIDTH-1:0] = fn;
        end else if (pick < 24) begin
            op = OP_ADDI;
        end else if (pick < 28) begin
            op = OP_JUMP;
        end else if (pick < 30) begin
            op = 6'($random(seed));
            if (op == OP_RTYPE || op == OP_JUMP || op == OP_ADDI || op == OP_RESET) begin
                op = op ^ 6'h10;
            end
        end else if (pick < 31) begin
            fn = 6'($random(seed));
            if (fn == FUNCT_ADD || fn == FUNCT_SUB || fn == FUNCT_AND || fn == FUNCT_SLT) begin
                fn = 6'b000000;
            end
            off[`FUNCT_WIDTH-1:0] = fn;
        end else begin
            op = OP_RESET;
        end
        opcode <= op;
        offset <= off;
    endtask

    initial begin
        seed = 32'hd9f3;
        opcode = OP_RTYPE;
        offset = '0;
        resetRequest = 1'b0;
        issued = 0;
        haltCycles = 0;
        fetchSeen = 1'b0;
        runDone = 1'b0;
    end

    // Outputs are settled at the falling edge.
    always @(negedge clock) begin
        fetchSeen = irWrite;
        if (resetOut) begin
            haltCycles = haltCycles + 1;
        end else begin
            haltCycles = 0;
        end
    end

    // New instruction register contents on the irWrite edge.
    always @(posedge clock) begin
        resetRequest <= 1'b0;
        if (fetchSeen) begin
            if (issued == numInstructions) begin
                runDone <= 1'b1;
            end else begin
                drawInstruction();
                issued <= issued + 1;
            end
        end
        if (haltCycles == haltWait) begin
            resetRequest <= 1'b1;
        end
    end

    initial begin
        wait (runDone || timedOut);
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- controlUnit.f
+incdir+include
rtl/isaPkg.sv
rtl/controlPkg.sv
rtl/instructionDecoder.sv
rtl/stepSequencer.sv
rtl/controlWordGenerator.sv
rtl/controlUnit.sv
test/clockGen.sv
test/controlUnitChecker.sv
test/controlUnitTb.sv

//--- build.sh
#!/bin/sh
# Builds the controlUnit testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module controlUnitTb \
    -f controlUnit.f \
    -o controlUnitSim

./obj_dir/controlUnitSim | tee sim.log

if grep -q -x "all tests passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
